// ==== hdl/mult_ft_settings.svh ====
////////////////////////////////////////////////////////////
// fault-tolerant multiplier settings
// widths, lane and replica counts, register offsets and the
// error count at which a replica is taken as permanently faulty
////////////////////////////////////////////////////////////

`ifndef MULT_FT_SETTINGS_SVH
`define MULT_FT_SETTINGS_SVH

`define MULT_FT_WIDTH          32
`define MULT_FT_LANES          4
`define MULT_FT_REPLICAS       3
`define MULT_FT_ADDR_WIDTH     8
`define MULT_FT_CNT_WIDTH      16
`define MULT_FT_PERM_THRESHOLD 4

// APB register offsets
`define MULT_FT_REG_CONFIG     8'h00
`define MULT_FT_REG_CNT0       8'h04
`define MULT_FT_REG_CNT1       8'h08
`define MULT_FT_REG_CNT2       8'h0C
`define MULT_FT_REG_STATUS     8'h10

`endif

// ==== hdl/mult_ft_pkg.sv ====
////////////////////////////////////////////////////////////
// fault-tolerant multiplier package
// operand, address and counter types, operation and
// voter mode encodings
////////////////////////////////////////////////////////////

package mult_ft_pkg;

`include "mult_ft_settings.svh"

	// datapath and bus types
	typedef logic [`MULT_FT_WIDTH-1:0]      word_t;
	typedef logic [`MULT_FT_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [`MULT_FT_CNT_WIDTH-1:0]  err_count_t;
	typedef logic [`MULT_FT_REPLICAS-1:0]   replica_mask_t;

	// operation shared by all lanes
	typedef enum logic [1:0] {
		MULT_OP_MUL   = 2'd0,
		MULT_OP_MULH  = 2'd1,
		MULT_OP_MULHU = 2'd2
	} mult_op_e;

	// voter operating mode, as held in CONFIG bits 4..3
	typedef enum logic [1:0] {
		VOTE_MAJORITY = 2'd0,
		VOTE_ONLY_TWO = 2'd1,
		VOTE_BYPASS   = 2'd2
	} vote_mode_e;

endpackage

// ==== hdl/lane_select.sv ====
////////////////////////////////////////////////////////////
// lane selector
// feeds each replica from its own issue lane, or from the
// last lane when that replica is switched to the spare
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "mult_ft_settings.svh"

module lane_select (
	input  mult_ft_pkg::word_t [`MULT_FT_LANES-1:0]    op_a_i,
	input  mult_ft_pkg::word_t [`MULT_FT_LANES-1:0]    op_b_i,
	input  mult_ft_pkg::replica_mask_t                 spare_sel_i,
	output mult_ft_pkg::word_t [`MULT_FT_REPLICAS-1:0] rep_a_o,
	output mult_ft_pkg::word_t [`MULT_FT_REPLICAS-1:0] rep_b_o
);

	// the spare is always the highest lane
	localparam int SPARE_LANE = `MULT_FT_LANES - 1;

	always_comb begin
		for (int r = 0; r < `MULT_FT_REPLICAS; r++) begin
			if (spare_sel_i[r]) begin
				rep_a_o[r] = op_a_i[SPARE_LANE];
				rep_b_o[r] = op_b_i[SPARE_LANE];
			end else begin
				rep_a_o[r] = op_a_i[r];
				rep_b_o[r] = op_b_i[r];
			end
		end
	end

endmodule

// ==== hdl/mult_core.sv ====
////////////////////////////////////////////////////////////
// multiplier replica
// two-stage pipelined 32x32 multiply, stalled by ex_ready_i,
// returning the low word or the signed/unsigned high word
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "mult_ft_settings.svh"

module mult_core (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  valid_i,
	input  logic                  ex_ready_i,
	input  mult_ft_pkg::mult_op_e op_i,
	input  mult_ft_pkg::word_t    op_a_i,
	input  mult_ft_pkg::word_t    op_b_i,
	output mult_ft_pkg::word_t    result_o,
	output logic                  result_valid_o
);

	localparam int W = `MULT_FT_WIDTH;

	logic                  sign_ext;
	logic signed [W:0]     a_q;
	logic signed [W:0]     b_q;
	mult_ft_pkg::mult_op_e op1_q;
	mult_ft_pkg::mult_op_e op2_q;
	logic                  valid1_q;
	logic                  valid2_q;
	logic signed [2*W-1:0] prod_full;
	logic [2*W-1:0]        prod_q;

	// only mulh sign-extends the operands
	// the low word does not depend on the signedness
	assign sign_ext = (op_i == mult_ft_pkg::MULT_OP_MULH);

	assign prod_full = a_q * b_q;

	// both stages hold while the consumer stalls
	always_ff @(posedge clk) begin
		if (ex_ready_i) begin
			a_q    <= {sign_ext & op_a_i[W-1], op_a_i};
			b_q    <= {sign_ext & op_b_i[W-1], op_b_i};
			op1_q  <= op_i;
			prod_q <= prod_full;
			op2_q  <= op1_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid1_q <= 1'b0;
			valid2_q <= 1'b0;
		end else if (ex_ready_i) begin
			valid1_q <= valid_i;
			valid2_q <= valid1_q;
		end
	end

	// word select on the registered product
	// mul takes the low word
	always_comb begin
		case (op2_q)
			mult_ft_pkg::MULT_OP_MULH,
			mult_ft_pkg::MULT_OP_MULHU: result_o = prod_q[2*W-1:W];
			default:                    result_o = prod_q[W-1:0];
		endcase
	end

	assign result_valid_o = valid2_q;

endmodule

// ==== hdl/tmr_voter.sv ====
////////////////////////////////////////////////////////////
// replica voter
// majority vote over three replicas, pair compare with one
// replica excluded, or straight bypass of a single replica
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "mult_ft_settings.svh"

module tmr_voter (
	input  mult_ft_pkg::word_t [`MULT_FT_REPLICAS-1:0] rep_result_i,
	input  mult_ft_pkg::replica_mask_t                 rep_valid_i,
	input  mult_ft_pkg::vote_mode_e                    mode_i,
	input  logic [1:0]                                 pick_i,
	output mult_ft_pkg::word_t                         result_o,
	output logic                                       result_valid_o,
	output mult_ft_pkg::replica_mask_t                 flagged_o,
	output logic                                       err_detected_o,
	output logic                                       err_corrected_o
);

	localparam int W = `MULT_FT_WIDTH;

	// valid bit travels with the data so both see the same vote
	logic [`MULT_FT_REPLICAS-1:0][W:0] tup;
	logic [W:0]                        voted;
	logic [1:0]                        pick_idx;
	logic [1:0]                        first_idx;
	logic [1:0]                        second_idx;
	mult_ft_pkg::replica_mask_t        flags;
	logic                              detected;
	logic                              corrected;

	always_comb begin
		for (int r = 0; r < `MULT_FT_REPLICAS; r++) begin
			tup[r] = {rep_valid_i[r], rep_result_i[r]};
		end
	end

	// pick 3 falls back to replica 0
	assign pick_idx = (pick_i == 2'd3) ? 2'd0 : pick_i;

	// remaining pair for only-two mode, lower index first
	assign first_idx  = (pick_idx == 2'd0) ? 2'd1 : 2'd0;
	assign second_idx = (pick_idx == 2'd2) ? 2'd1 : 2'd2;

	always_comb begin
		voted     = tup[0];
		flags     = '0;
		detected  = 1'b0;
		corrected = 1'b0;
		case (mode_i)
			mult_ft_pkg::VOTE_BYPASS: begin
				voted = tup[pick_idx];
			end
			mult_ft_pkg::VOTE_ONLY_TWO: begin
				voted = tup[first_idx];
				if (tup[first_idx] != tup[second_idx]) begin
					detected          = 1'b1;
					flags[first_idx]  = 1'b1;
					flags[second_idx] = 1'b1;
				end
			end
			default: begin
				// majority, any single outlier is corrected
				if (tup[0] == tup[1] && tup[0] == tup[2]) begin
					voted = tup[0];
				end else if (tup[0] == tup[1]) begin
					{detected, corrected, flags[2]} = 3'b111;
				end else if (tup[0] == tup[2]) begin
					{detected, corrected, flags[1]} = 3'b111;
				end else if (tup[1] == tup[2]) begin
					voted = tup[1];
					{detected, corrected, flags[0]} = 3'b111;
				end else begin
					detected = 1'b1;
				end
			end
		endcase
	end

	assign result_o        = voted[W-1:0];
	assign result_valid_o  = voted[W];
	assign flagged_o       = flags & {`MULT_FT_REPLICAS{voted[W]}};
	assign err_detected_o  = detected & voted[W];
	assign err_corrected_o = corrected & voted[W];

endmodule

// ==== hdl/ft_csr.sv ====
////////////////////////////////////////////////////////////
// fault-tolerance control and status registers
// APB slave with the configuration register, one saturating
// error counter per replica and sticky permanent-fault flags
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "mult_ft_settings.svh"

module ft_csr (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  mult_ft_pkg::apb_addr_t     paddr_i,
	input  mult_ft_pkg::word_t         pwdata_i,
	output mult_ft_pkg::word_t         prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,
	input  mult_ft_pkg::replica_mask_t flagged_i,
	input  logic                       count_en_i,
	output mult_ft_pkg::replica_mask_t spare_sel_o,
	output mult_ft_pkg::vote_mode_e    mode_o,
	output logic [1:0]                 pick_o,
	output mult_ft_pkg::replica_mask_t perm_faulty_o
);

	mult_ft_pkg::replica_mask_t                          spare_sel_q;
	mult_ft_pkg::vote_mode_e                             mode_q;
	logic [1:0]                                          pick_q;
	mult_ft_pkg::err_count_t [`MULT_FT_REPLICAS-1:0]     cnt_q;
	mult_ft_pkg::replica_mask_t                          perm_q;
	mult_ft_pkg::word_t                                  rdata;
	mult_ft_pkg::replica_mask_t                          cnt_hit;
	logic                                                config_hit;
	logic                                                status_hit;
	logic                                                mapped;
	logic                                                access;
	logic                                                wr_ok;

	////////////////////////////////////////////////////////////
	// address decode and read data
	////////////////////////////////////////////////////////////

	always_comb begin
		rdata      = '0;
		cnt_hit    = '0;
		config_hit = 1'b0;
		status_hit = 1'b0;
		mapped     = 1'b1;
		case (paddr_i)
			`MULT_FT_REG_CONFIG: begin
				config_hit = 1'b1;
				rdata[6:0] = {pick_q, mode_q, spare_sel_q};
			end
			`MULT_FT_REG_CNT0: begin
				cnt_hit[0]                     = 1'b1;
				rdata[`MULT_FT_CNT_WIDTH-1:0] = cnt_q[0];
			end
			`MULT_FT_REG_CNT1: begin
				cnt_hit[1]                     = 1'b1;
				rdata[`MULT_FT_CNT_WIDTH-1:0] = cnt_q[1];
			end
			`MULT_FT_REG_CNT2: begin
				cnt_hit[2]                     = 1'b1;
				rdata[`MULT_FT_CNT_WIDTH-1:0] = cnt_q[2];
			end
			`MULT_FT_REG_STATUS: begin
				status_hit                   = 1'b1;
				rdata[`MULT_FT_REPLICAS-1:0] = perm_q;
			end
			default: mapped = 1'b0;
		endcase
	end

	// no wait states, every access ends in its access phase
	assign access    = psel_i & penable_i;
	assign pready_o  = access;
	assign pslverr_o = access & (~mapped | (pwrite_i & status_hit));
	assign wr_ok     = access & pwrite_i & mapped & ~status_hit;
	assign prdata_o  = rdata;

	////////////////////////////////////////////////////////////
	// configuration
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			spare_sel_q <= '0;
			mode_q      <= mult_ft_pkg::VOTE_MAJORITY;
			pick_q      <= 2'd0;
		end else if (wr_ok && config_hit) begin
			spare_sel_q <= pwdata_i[2:0];
			mode_q      <= mult_ft_pkg::vote_mode_e'(pwdata_i[4:3]);
			pick_q      <= pwdata_i[6:5];
		end
	end

	// error counters, a clearing write wins over an increment
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cnt_q  <= '0;
			perm_q <= '0;
		end else begin
			for (int r = 0; r < `MULT_FT_REPLICAS; r++) begin
				if (wr_ok && cnt_hit[r]) begin
					cnt_q[r]  <= '0;
					perm_q[r] <= 1'b0;
				end else if (count_en_i && flagged_i[r]) begin
					if (cnt_q[r] != '1)
						cnt_q[r] <= cnt_q[r] + 1'b1;
					// sticky once the count reaches the threshold
					if (cnt_q[r] >= `MULT_FT_PERM_THRESHOLD - 1)
						perm_q[r] <= 1'b1;
				end
			end
		end
	end

	assign spare_sel_o   = spare_sel_q;
	assign mode_o        = mode_q;
	assign pick_o        = pick_q;
	assign perm_faulty_o = perm_q;

endmodule

// ==== hdl/mult_ft_top.sv ====
////////////////////////////////////////////////////////////
// fault-tolerant multiplier top level
// lane selector, three multiplier replicas, voter and the
// APB register block for configuration and fault counting
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "mult_ft_settings.svh"

module mult_ft_top (
	input  logic                                    clk,
	input  logic                                    reset_i,

	// issue side
	input  logic                                    valid_i,
	input  mult_ft_pkg::mult_op_e                   op_i,
	input  mult_ft_pkg::word_t [`MULT_FT_LANES-1:0] op_a_i,
	input  mult_ft_pkg::word_t [`MULT_FT_LANES-1:0] op_b_i,
	input  logic                                    ex_ready_i,

	// result side
	output mult_ft_pkg::word_t                      result_o,
	output logic                                    result_valid_o,
	output logic                                    err_detected_o,
	output logic                                    err_corrected_o,
	output mult_ft_pkg::replica_mask_t              perm_faulty_o,

	// APB
	input  logic                                    psel_i,
	input  logic                                    penable_i,
	input  logic                                    pwrite_i,
	input  mult_ft_pkg::apb_addr_t                  paddr_i,
	input  mult_ft_pkg::word_t                      pwdata_i,
	output mult_ft_pkg::word_t                      prdata_o,
	output logic                                    pready_o,
	output logic                                    pslverr_o
);

	mult_ft_pkg::word_t [`MULT_FT_REPLICAS-1:0] rep_a;
	mult_ft_pkg::word_t [`MULT_FT_REPLICAS-1:0] rep_b;
	mult_ft_pkg::word_t [`MULT_FT_REPLICAS-1:0] rep_result;
	mult_ft_pkg::replica_mask_t                 rep_valid;
	mult_ft_pkg::replica_mask_t                 spare_sel;
	mult_ft_pkg::replica_mask_t                 flagged;
	mult_ft_pkg::vote_mode_e                    mode;
	logic [1:0]                                 pick;
	logic                                       voted_valid;
	logic                                       count_en;

	lane_select lane_select_i (
		.op_a_i      ( op_a_i    ),
		.op_b_i      ( op_b_i    ),
		.spare_sel_i ( spare_sel ),
		.rep_a_o     ( rep_a     ),
		.rep_b_o     ( rep_b     )
	);

	for (genvar r = 0; r < `MULT_FT_REPLICAS; r++) begin : gen_replica
		mult_core mult_core_i (
			.clk            ( clk           ),
			.reset_i        ( reset_i       ),
			.valid_i        ( valid_i       ),
			.ex_ready_i     ( ex_ready_i    ),
			.op_i           ( op_i          ),
			.op_a_i         ( rep_a[r]      ),
			.op_b_i         ( rep_b[r]      ),
			.result_o       ( rep_result[r] ),
			.result_valid_o ( rep_valid[r]  )
		);
	end

	tmr_voter tmr_voter_i (
		.rep_result_i    ( rep_result      ),
		.rep_valid_i     ( rep_valid       ),
		.mode_i          ( mode            ),
		.pick_i          ( pick            ),
		.result_o        ( result_o        ),
		.result_valid_o  ( voted_valid     ),
		.flagged_o       ( flagged         ),
		.err_detected_o  ( err_detected_o  ),
		.err_corrected_o ( err_corrected_o )
	);

	// a result counts only once the consumer takes it
	assign count_en       = voted_valid & ex_ready_i;
	assign result_valid_o = voted_valid;

	ft_csr ft_csr_i (
		.clk           ( clk           ),
		.reset_i       ( reset_i       ),
		.psel_i        ( psel_i        ),
		.penable_i     ( penable_i     ),
		.pwrite_i      ( pwrite_i      ),
		.paddr_i       ( paddr_i       ),
		.pwdata_i      ( pwdata_i      ),
		.prdata_o      ( prdata_o      ),
		.pready_o      ( pready_o      ),
		.pslverr_o     ( pslverr_o     ),
		.flagged_i     ( flagged       ),
		.count_en_i    ( count_en      ),
		.spare_sel_o   ( spare_sel     ),
		.mode_o        ( mode          ),
		.pick_o        ( pick          ),
		.perm_faulty_o ( perm_faulty_o )
	);

endmodule

// ==== verification/mult_ft_tb.sv ====
////////////////////////////////////////////////////////////
// fault-tolerant multiplier testbench
// directed tests for voting, spare lane, stall behavior and
// the APB register block, checked against a multiply model
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "mult_ft_settings.svh"

module mult_ft_tb;

	localparam int W     = `MULT_FT_WIDTH;
	localparam int LANES = `MULT_FT_LANES;

	typedef mult_ft_pkg::word_t [LANES-1:0] lanes_t;

	logic                       clk = 1'b0;
	logic                       reset;
	logic                       valid;
	mult_ft_pkg::mult_op_e      op;
	lanes_t                     op_a;
	lanes_t                     op_b;
	logic                       ex_ready;
	mult_ft_pkg::word_t         result;
	logic                       result_valid;
	logic                       err_det;
	logic                       err_cor;
	mult_ft_pkg::replica_mask_t perm_faulty;
	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	mult_ft_pkg::apb_addr_t     paddr;
	mult_ft_pkg::word_t         pwdata;
	mult_ft_pkg::word_t         prdata;
	logic                       pready;
	logic                       pslverr;

	logic [31:0] lfsr;
	int          checks;
	int          errors;
	int          tests;

	mult_ft_top mult_ft_top_i (
		.clk             ( clk          ),
		.reset_i         ( reset        ),
		.valid_i         ( valid        ),
		.op_i            ( op           ),
		.op_a_i          ( op_a         ),
		.op_b_i          ( op_b         ),
		.ex_ready_i      ( ex_ready     ),
		.result_o        ( result       ),
		.result_valid_o  ( result_valid ),
		.err_detected_o  ( err_det      ),
		.err_corrected_o ( err_cor      ),
		.perm_faulty_o   ( perm_faulty  ),
		.psel_i          ( psel         ),
		.penable_i       ( penable      ),
		.pwrite_i        ( pwrite       ),
		.paddr_i         ( paddr        ),
		.pwdata_i        ( pwdata       ),
		.prdata_o        ( prdata       ),
		.pready_o        ( pready       ),
		.pslverr_o       ( pslverr      )
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// stimulus, reference model and checking helpers
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function logic next_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function mult_ft_pkg::word_t random_word();
		mult_ft_pkg::word_t w;
		w = '0;
		for (int i = 0; i < W; i++)
			w = {w[W-2:0], next_bit()};
		return w;
	endfunction

	function automatic lanes_t all_lanes(input mult_ft_pkg::word_t w);
		lanes_t l;
		for (int i = 0; i < LANES; i++)
			l[i] = w;
		return l;
	endfunction

	// low word or high word of the signed or unsigned 64-bit product
	function automatic mult_ft_pkg::word_t model(input mult_ft_pkg::mult_op_e o,
			input mult_ft_pkg::word_t a, input mult_ft_pkg::word_t b);
		logic [2*W-1:0]        uprod;
		logic signed [2*W-1:0] sprod;
		uprod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
		sprod = $signed({{W{a[W-1]}}, a}) * $signed({{W{b[W-1]}}, b});
		case (o)
			mult_ft_pkg::MULT_OP_MULH:  return sprod[2*W-1:W];
			mult_ft_pkg::MULT_OP_MULHU: return uprod[2*W-1:W];
			default:                    return uprod[W-1:0];
		endcase
	endfunction

	task automatic expect_eq(input string name, input logic [W-1:0] got,
			input logic [W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - start);
	endtask

	////////////////////////////////////////////////////////////
	// APB master
	////////////////////////////////////////////////////////////

	task automatic apb_access(input logic write, input mult_ft_pkg::apb_addr_t addr,
			input mult_ft_pkg::word_t data, output mult_ft_pkg::word_t rdata,
			output logic err);
		logic done;
		done  = 1'b0;
		rdata = '0;
		err   = 1'b0;
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		for (int n = 0; n < 4 && !done; n++) begin
			@(negedge clk);
			if (pready === 1'b1) begin
				done  = 1'b1;
				rdata = prdata;
				err   = pslverr;
			end
		end
		if (!done)
			timeout_fail("pready_o");
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input mult_ft_pkg::apb_addr_t addr,
			input mult_ft_pkg::word_t data, output logic err);
		mult_ft_pkg::word_t unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input mult_ft_pkg::apb_addr_t addr,
			output mult_ft_pkg::word_t data, output logic err);
		apb_access(1'b0, addr, '0, data, err);
	endtask

	task automatic write_ok(input mult_ft_pkg::apb_addr_t addr, input mult_ft_pkg::word_t data);
		logic err;
		apb_write(addr, data, err);
		expect_eq("pslverr_o", err, 1'b0);
	endtask

	task automatic read_expect(input mult_ft_pkg::apb_addr_t addr,
			input mult_ft_pkg::word_t exp, input string name);
		mult_ft_pkg::word_t data;
		logic               err;
		apb_read(addr, data, err);
		expect_eq(name, data, exp);
		expect_eq("pslverr_o", err, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// issue side
	////////////////////////////////////////////////////////////

	task automatic issue(input mult_ft_pkg::mult_op_e o, input lanes_t la, input lanes_t lb);
		@(posedge clk);
		#1;
		valid = 1'b1;
		op    = o;
		op_a  = la;
		op_b  = lb;
		@(posedge clk);
		#1;
		valid = 1'b0;
	endtask

	// returns at the edge where the consumer takes the result
	task automatic wait_result(output mult_ft_pkg::word_t res, output logic det,
			output logic cor);
		logic seen;
		seen = 1'b0;
		res  = '0;
		det  = 1'b0;
		cor  = 1'b0;
		for (int n = 0; n < 20 && !seen; n++) begin
			@(negedge clk);
			if (result_valid === 1'b1) begin
				seen = 1'b1;
				res  = result;
				det  = err_det;
				cor  = err_cor;
			end
		end
		if (!seen)
			timeout_fail("result_valid_o");
		@(posedge clk);
		#1;
	endtask

	task automatic run_and_check(input mult_ft_pkg::mult_op_e o, input lanes_t la,
			input lanes_t lb, input mult_ft_pkg::word_t exp, input logic exp_det,
			input logic exp_cor);
		mult_ft_pkg::word_t res;
		logic               det;
		logic               cor;
		issue(o, la, lb);
		wait_result(res, det, cor);
		expect_eq("result_o", res, exp);
		expect_eq("err_detected_o", det, exp_det);
		expect_eq("err_corrected_o", cor, exp_cor);
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic reset_and_ops();
		int                    start;
		mult_ft_pkg::word_t    a;
		mult_ft_pkg::word_t    b;
		mult_ft_pkg::mult_op_e o;
		start = errors;
		expect_eq("result_valid_o", result_valid, 1'b0);
		expect_eq("perm_faulty_o", perm_faulty, '0);
		read_expect(`MULT_FT_REG_STATUS, '0, "STATUS");
		read_expect(`MULT_FT_REG_CNT0, '0, "CNT0");
		read_expect(`MULT_FT_REG_CNT1, '0, "CNT1");
		read_expect(`MULT_FT_REG_CNT2, '0, "CNT2");
		for (int i = 0; i < 3; i++) begin
			o = mult_ft_pkg::mult_op_e'(i);
			a = random_word();
			b = random_word();
			run_and_check(o, all_lanes(a), all_lanes(b), model(o, a, b), 1'b0, 1'b0);
		end
		report_test("reset state and operations", start);
	endtask

	task automatic majority_fix();
		int                 start;
		mult_ft_pkg::word_t a;
		mult_ft_pkg::word_t b;
		lanes_t             la;
		start = errors;
		a     = random_word();
		// an odd multiplier makes a one-bit operand error visible in the low word
		b     = random_word() | 32'h1;
		la    = all_lanes(a);
		la[1] = a ^ 32'h1;
		for (int k = 1; k <= `MULT_FT_PERM_THRESHOLD; k++) begin
			run_and_check(mult_ft_pkg::MULT_OP_MUL, la, all_lanes(b),
				model(mult_ft_pkg::MULT_OP_MUL, a, b), 1'b1, 1'b1);
			read_expect(`MULT_FT_REG_CNT1, k, "CNT1");
			if (k < `MULT_FT_PERM_THRESHOLD)
				expect_eq("perm_faulty_o", perm_faulty, '0);
		end
		expect_eq("perm_faulty_o", perm_faulty, 3'b010);
		read_expect(`MULT_FT_REG_STATUS, 32'h2, "STATUS");
		write_ok(`MULT_FT_REG_CNT1, 32'h0);
		read_expect(`MULT_FT_REG_CNT1, '0, "CNT1");
		read_expect(`MULT_FT_REG_STATUS, '0, "STATUS");
		expect_eq("perm_faulty_o", perm_faulty, '0);
		report_test("majority correction and permanent fault", start);
	endtask

	task automatic spare_lane();
		int                 start;
		mult_ft_pkg::word_t a;
		mult_ft_pkg::word_t b;
		lanes_t             la;
		start = errors;
		a     = random_word();
		b     = random_word() | 32'h1;
		la    = all_lanes(a);
		la[1] = a ^ 32'h1;
		// replica 1 moves to lane 3
		write_ok(`MULT_FT_REG_CONFIG, 32'h2);
		run_and_check(mult_ft_pkg::MULT_OP_MUL, la, all_lanes(b),
			model(mult_ft_pkg::MULT_OP_MUL, a, b), 1'b0, 1'b0);
		read_expect(`MULT_FT_REG_CNT1, '0, "CNT1");
		write_ok(`MULT_FT_REG_CONFIG, 32'h0);
		report_test("spare lane", start);
	endtask

	task automatic pair_and_bypass();
		int                 start;
		mult_ft_pkg::word_t a;
		mult_ft_pkg::word_t b;
		lanes_t             la;
		start = errors;
		a     = random_word();
		b     = random_word() | 32'h1;
		// only-two mode with replica 2 excluded
		write_ok(`MULT_FT_REG_CONFIG, 32'h48);
		la    = all_lanes(a);
		la[2] = a ^ 32'h1;
		run_and_check(mult_ft_pkg::MULT_OP_MUL, la, all_lanes(b),
			model(mult_ft_pkg::MULT_OP_MUL, a, b), 1'b0, 1'b0);
		la    = all_lanes(a);
		la[0] = a ^ 32'h1;
		run_and_check(mult_ft_pkg::MULT_OP_MUL, la, all_lanes(b),
			model(mult_ft_pkg::MULT_OP_MUL, a ^ 32'h1, b), 1'b1, 1'b0);
		read_expect(`MULT_FT_REG_CNT0, 32'h1, "CNT0");
		read_expect(`MULT_FT_REG_CNT1, 32'h1, "CNT1");
		read_expect(`MULT_FT_REG_CNT2, '0, "CNT2");
		// bypass of replica 1
		write_ok(`MULT_FT_REG_CONFIG, 32'h30);
		la    = all_lanes(a);
		la[1] = a ^ 32'h1;
		run_and_check(mult_ft_pkg::MULT_OP_MUL, la, all_lanes(b),
			model(mult_ft_pkg::MULT_OP_MUL, a ^ 32'h1, b), 1'b0, 1'b0);
		read_expect(`MULT_FT_REG_CNT1, 32'h1, "CNT1");
		write_ok(`MULT_FT_REG_CONFIG, 32'h0);
		report_test("only-two and bypass modes", start);
	endtask

	task automatic stall_burst();
		int                 start;
		int                 got;
		mult_ft_pkg::word_t a [3];
		mult_ft_pkg::word_t b [3];
		mult_ft_pkg::word_t exp_res [3];
		mult_ft_pkg::word_t held;
		logic               held_ok;
		start   = errors;
		got     = 0;
		held    = '0;
		held_ok = 1'b0;
		for (int i = 0; i < 3; i++) begin
			a[i]       = random_word();
			b[i]       = random_word();
			exp_res[i] = model(mult_ft_pkg::mult_op_e'(i), a[i], b[i]);
		end
		fork
			begin
				@(posedge clk);
				#1;
				valid = 1'b1;
				op    = mult_ft_pkg::MULT_OP_MUL;
				op_a  = all_lanes(a[0]);
				op_b  = all_lanes(b[0]);
				@(posedge clk);
				#1;
				op   = mult_ft_pkg::MULT_OP_MULH;
				op_a = all_lanes(a[1]);
				op_b = all_lanes(b[1]);
				@(posedge clk);
				#1;
				// third operation waits through the stall
				ex_ready = 1'b0;
				op       = mult_ft_pkg::MULT_OP_MULHU;
				op_a     = all_lanes(a[2]);
				op_b     = all_lanes(b[2]);
				repeat (4) @(posedge clk);
				#1;
				ex_ready = 1'b1;
				@(posedge clk);
				#1;
				valid = 1'b0;
			end
			begin
				for (int n = 0; n < 30 && got < 3; n++) begin
					@(negedge clk);
					if (result_valid === 1'b1 && ex_ready === 1'b1) begin
						expect_eq("result_o", result, exp_res[got]);
						got++;
					end else if (result_valid === 1'b1) begin
						if (held_ok)
							expect_eq("result_o", result, held);
						held    = result;
						held_ok = 1'b1;
					end
				end
				if (got < 3)
					timeout_fail("burst results");
			end
		join
		if (!held_ok) begin
			errors++;
			$display("no result was seen while ex_ready_i was low");
		end
		report_test("stalled burst", start);
	endtask

	task automatic bus_errors();
		int                 start;
		mult_ft_pkg::word_t data;
		logic               err;
		start = errors;
		write_ok(`MULT_FT_REG_CONFIG, 32'h20);
		apb_write(8'h14, 32'h7f, err);
		expect_eq("pslverr_o", err, 1'b1);
		apb_read(8'h40, data, err);
		expect_eq("pslverr_o", err, 1'b1);
		expect_eq("prdata_o", data, '0);
		apb_write(`MULT_FT_REG_STATUS, 32'h7, err);
		expect_eq("pslverr_o", err, 1'b1);
		read_expect(`MULT_FT_REG_CONFIG, 32'h20, "CONFIG");
		write_ok(`MULT_FT_REG_CONFIG, 32'h0);
		report_test("bus errors", start);
	endtask

	initial begin
		reset    = 1'b1;
		valid    = 1'b0;
		op       = mult_ft_pkg::MULT_OP_MUL;
		op_a     = '0;
		op_b     = '0;
		ex_ready = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		lfsr     = 32'hd78a18fa;
		checks   = 0;
		errors   = 0;
		tests    = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		reset_and_ops();
		majority_fix();
		spare_lane();
		pair_and_bypass();
		stall_burst();
		bus_errors();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/mult_ft_pkg.sv
hdl/lane_select.sv
hdl/mult_core.sv
hdl/tmr_voter.sv
hdl/ft_csr.sv
hdl/mult_ft_top.sv
verification/mult_ft_tb.sv

// ==== Bender.yml ====
package:
  name: mult_ft

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mult_ft_pkg.sv
      - hdl/lane_select.sv
      - hdl/mult_core.sv
      - hdl/tmr_voter.sv
      - hdl/ft_csr.sv
      - hdl/mult_ft_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/mult_ft_tb.sv
